// File: src/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;      // data word or byte address
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;    // instr[30:25]
	typedef logic [1:0]  imm_sel_t;
	typedef logic [2:0]  src2_sel_t;
	typedef logic [1:0]  wb_sel_t;
	typedef logic [2:0]  alu_op_t;

	localparam int MEM_ADDR_W = 8; // data memory word index, addr bits 9:2

	// major opcodes, anything else is a no-op
	localparam opcode_t OP_ADD  = 6'h00;
	localparam opcode_t OP_SUB  = 6'h01;
	localparam opcode_t OP_AND  = 6'h02;
	localparam opcode_t OP_XOR  = 6'h03;
	localparam opcode_t OP_OR   = 6'h04;
	localparam opcode_t OP_SLL  = 6'h05;
	localparam opcode_t OP_SLLI = 6'h08;
	localparam opcode_t OP_LWI  = 6'h12;
	localparam opcode_t OP_SWI  = 6'h16;
	localparam opcode_t OP_LW   = 6'h1a;
	localparam opcode_t OP_SW   = 6'h1b;
	localparam opcode_t OP_MOVI = 6'h22;
	localparam opcode_t OP_BEQ  = 6'h26;
	localparam opcode_t OP_BNE  = 6'h27;
	localparam opcode_t OP_ADDI = 6'h28;
	localparam opcode_t OP_ORI  = 6'h2c;

	localparam imm_sel_t IMM_5BIT_ZE  = 2'd0;
	localparam imm_sel_t IMM_15BIT_SE = 2'd1;
	localparam imm_sel_t IMM_15BIT_ZE = 2'd2;
	localparam imm_sel_t IMM_20BIT_SE = 2'd3;

	localparam src2_sel_t ALUSRC2_RBDATA = 3'd0;
	localparam src2_sel_t ALUSRC2_IMM    = 3'd1;
	localparam src2_sel_t ALUSRC2_LSWI   = 3'd2; // imm15 sign extended, word scaled
	localparam src2_sel_t ALUSRC2_LSW    = 3'd3; // rb << sub_op_sv
	localparam src2_sel_t ALUSRC2_BENX   = 3'd4; // rt, branch compare

	localparam wb_sel_t WRREG_ALURESULT = 2'd0;
	localparam wb_sel_t WRREG_IMMDATA   = 2'd1;
	localparam wb_sel_t WRREG_MEM       = 2'd2;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLL = 3'd5;

endpackage

// File: src/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  core_pkg::word_t     instr,
	input  logic                instr_valid,
	output core_pkg::reg_addr_t ra_addr,
	output core_pkg::reg_addr_t rb_addr,
	output core_pkg::reg_addr_t rt_addr,
	output logic [4:0]          imm_5bit,
	output logic [14:0]         imm_15bit,
	output logic [19:0]         imm_20bit,
	output logic [1:0]          sub_op_sv,
	output core_pkg::imm_sel_t  select_imm_extend,
	output core_pkg::src2_sel_t select_alu_src2,
	output core_pkg::wb_sel_t   select_write_reg,
	output core_pkg::alu_op_t   alu_op,
	output logic                reg_we,
	output logic                mem_we,
	output logic                is_branch,
	output logic                branch_ne
);
	import core_pkg::*;

	opcode_t opcode;
	logic    reg_we_d;
	logic    mem_we_d;
	logic    branch_d;
	logic    branch_ne_d;

	assign opcode    = instr[30:25];
	assign rt_addr   = instr[24:20];
	assign ra_addr   = instr[19:15];
	assign rb_addr   = instr[14:10];
	assign sub_op_sv = instr[9:8];
	assign imm_5bit  = instr[14:10];
	assign imm_15bit = instr[14:0];
	assign imm_20bit = instr[19:0];

	always_comb begin
		select_imm_extend = IMM_15BIT_SE;
		select_alu_src2   = ALUSRC2_RBDATA;
		select_write_reg  = WRREG_ALURESULT;
		alu_op            = ALU_ADD;
		reg_we_d          = 1'b0;
		mem_we_d          = 1'b0;
		branch_d          = 1'b0;
		branch_ne_d       = 1'b0;

		case (opcode)
			OP_ADD: reg_we_d = 1'b1; // rt = ra op rb
			OP_SUB: begin
				alu_op   = ALU_SUB;
				reg_we_d = 1'b1;
			end
			OP_AND: begin
				alu_op   = ALU_AND;
				reg_we_d = 1'b1;
			end
			OP_OR: begin
				alu_op   = ALU_OR;
				reg_we_d = 1'b1;
			end
			OP_XOR: begin
				alu_op   = ALU_XOR;
				reg_we_d = 1'b1;
			end
			OP_SLL: begin
				alu_op   = ALU_SLL;
				reg_we_d = 1'b1;
			end
			OP_ADDI: begin
				select_alu_src2 = ALUSRC2_IMM;
				reg_we_d        = 1'b1;
			end
			OP_ORI: begin
				select_imm_extend = IMM_15BIT_ZE;
				select_alu_src2   = ALUSRC2_IMM;
				alu_op            = ALU_OR;
				reg_we_d          = 1'b1;
			end
			OP_SLLI: begin
				select_imm_extend = IMM_5BIT_ZE;
				select_alu_src2   = ALUSRC2_IMM;
				alu_op            = ALU_SLL;
				reg_we_d          = 1'b1;
			end
			OP_MOVI: begin
				select_imm_extend = IMM_20BIT_SE;
				select_alu_src2   = ALUSRC2_IMM;
				select_write_reg  = WRREG_IMMDATA; // bypasses the alu
				reg_we_d          = 1'b1;
			end
			OP_LWI: begin
				select_alu_src2  = ALUSRC2_LSWI;
				select_write_reg = WRREG_MEM;
				reg_we_d         = 1'b1;
			end
			OP_SWI: begin
				select_alu_src2 = ALUSRC2_LSWI;
				mem_we_d        = 1'b1;
			end
			OP_LW: begin
				select_alu_src2  = ALUSRC2_LSW;
				select_write_reg = WRREG_MEM;
				reg_we_d         = 1'b1;
			end
			OP_SW: begin
				select_alu_src2 = ALUSRC2_LSW;
				mem_we_d        = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				// ra - rt, outcome from the zero flag
				select_alu_src2 = ALUSRC2_BENX;
				alu_op          = ALU_SUB;
				branch_d        = 1'b1;
				branch_ne_d     = (opcode == OP_BNE);
			end
			default: ; // no-op
		endcase
	end

	assign reg_we    = instr_valid & reg_we_d;
	assign mem_we    = instr_valid & mem_we_d;
	assign is_branch = instr_valid & branch_d;
	assign branch_ne = instr_valid & branch_ne_d;

endmodule

// File: src/operand_muxes.sv
`timescale 1ns/1ps

module operand_muxes (
	input  logic [1:0]          sub_op_sv,
	input  core_pkg::word_t     reg_rb_data,
	input  core_pkg::word_t     reg_rt_data,
	input  core_pkg::word_t     mem_read_data,
	input  core_pkg::word_t     alu_output,
	input  logic [4:0]          imm_5bit,
	input  logic [14:0]         imm_15bit,
	input  logic [19:0]         imm_20bit,
	input  core_pkg::src2_sel_t select_alu_src2,
	input  core_pkg::imm_sel_t  select_imm_extend,
	input  core_pkg::wb_sel_t   select_write_reg,
	output core_pkg::word_t     alu_src2,
	output core_pkg::word_t     write_reg_data
);
	import core_pkg::*;

	word_t imm_extend;

	always_comb begin
		case (select_imm_extend)
			IMM_5BIT_ZE:  imm_extend = {27'd0, imm_5bit};
			IMM_15BIT_SE: imm_extend = {{17{imm_15bit[14]}}, imm_15bit};
			IMM_15BIT_ZE: imm_extend = {17'd0, imm_15bit};
			IMM_20BIT_SE: imm_extend = {{12{imm_20bit[19]}}, imm_20bit};
			default:      imm_extend = '0;
		endcase
	end

	always_comb begin
		case (select_alu_src2)
			ALUSRC2_RBDATA: begin
				alu_src2 = reg_rb_data;
			end
			ALUSRC2_IMM: begin
				alu_src2 = imm_extend;
			end
			ALUSRC2_LSWI: begin
				alu_src2 = {{15{imm_15bit[14]}}, imm_15bit, 2'b00}; // word offset
			end
			ALUSRC2_LSW: begin
				alu_src2 = reg_rb_data << sub_op_sv; // scaled index
			end
			ALUSRC2_BENX: begin
				alu_src2 = reg_rt_data;
			end
			default: begin
				alu_src2 = '0;
			end
		endcase
	end

	// movi data comes straight from the operand mux
	always_comb begin
		case (select_write_reg)
			WRREG_ALURESULT: write_reg_data = alu_output;
			WRREG_IMMDATA:   write_reg_data = alu_src2;
			WRREG_MEM:       write_reg_data = mem_read_data;
			default:         write_reg_data = '0;
		endcase
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  core_pkg::reg_addr_t ra_addr,
	input  core_pkg::reg_addr_t rb_addr,
	input  core_pkg::reg_addr_t rt_addr,
	input  core_pkg::reg_addr_t dbg_addr,
	input  logic                we,
	input  core_pkg::reg_addr_t wr_addr,
	input  core_pkg::word_t     wr_data,
	output core_pkg::word_t     ra_data,
	output core_pkg::word_t     rb_data,
	output core_pkg::word_t     rt_data,
	output core_pkg::word_t     dbg_data
);
	import core_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin // r0 stays zero
			regs[wr_addr] <= wr_data;
		end
	end

	// combinational reads
	assign ra_data  = regs[ra_addr];
	assign rb_data  = regs[rb_addr];
	assign rt_data  = regs[rt_addr];
	assign dbg_data = regs[dbg_addr];

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
	input  core_pkg::alu_op_t op,
	input  core_pkg::word_t   a,
	input  core_pkg::word_t   b,
	output core_pkg::word_t   result,
	output logic              zero
);
	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b; // also the branch compare
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_SLL: begin
				result = a << shamt;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: src/data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             we,
	input  logic [core_pkg::MEM_ADDR_W-1:0]  addr,
	input  core_pkg::word_t                  wr_data,
	output core_pkg::word_t                  rd_data
);
	import core_pkg::*;

	localparam int DEPTH = 1 << MEM_ADDR_W;

	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[addr] <= wr_data;
		end
	end

	assign rd_data = mem[addr]; // async read

endmodule

// File: src/exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  core_pkg::word_t     instr,
	input  core_pkg::reg_addr_t dbg_addr,
	output logic                wb_valid,
	output core_pkg::reg_addr_t wb_addr,
	output core_pkg::word_t     wb_data,
	output logic                br_taken,
	output core_pkg::word_t     dbg_data
);
	import core_pkg::*;

	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	reg_addr_t rt_addr;
	logic [4:0]  imm_5bit;
	logic [14:0] imm_15bit;
	logic [19:0] imm_20bit;
	logic [1:0]  sub_op_sv;
	imm_sel_t  select_imm_extend;
	src2_sel_t select_alu_src2;
	wb_sel_t   select_write_reg;
	alu_op_t   alu_op;
	logic      reg_we;
	logic      mem_we;
	logic      is_branch;
	logic      branch_ne;
	word_t     ra_data;
	word_t     rb_data;
	word_t     rt_data;
	word_t     alu_src2;
	word_t     alu_output;
	word_t     write_reg_data;
	word_t     mem_read_data;
	logic      zero;
	logic      br_next;

	instr_decode u_decode (
		.instr             (instr),
		.instr_valid       (instr_valid),
		.ra_addr           (ra_addr),
		.rb_addr           (rb_addr),
		.rt_addr           (rt_addr),
		.imm_5bit          (imm_5bit),
		.imm_15bit         (imm_15bit),
		.imm_20bit         (imm_20bit),
		.sub_op_sv         (sub_op_sv),
		.select_imm_extend (select_imm_extend),
		.select_alu_src2   (select_alu_src2),
		.select_write_reg  (select_write_reg),
		.alu_op            (alu_op),
		.reg_we            (reg_we),
		.mem_we            (mem_we),
		.is_branch         (is_branch),
		.branch_ne         (branch_ne)
	);

	reg_file u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.ra_addr  (ra_addr),
		.rb_addr  (rb_addr),
		.rt_addr  (rt_addr),
		.dbg_addr (dbg_addr),
		.we       (reg_we),
		.wr_addr  (rt_addr), // rt is always the destination
		.wr_data  (write_reg_data),
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.rt_data  (rt_data),
		.dbg_data (dbg_data)
	);

	operand_muxes u_muxes (
		.sub_op_sv         (sub_op_sv),
		.reg_rb_data       (rb_data),
		.reg_rt_data       (rt_data),
		.mem_read_data     (mem_read_data),
		.alu_output        (alu_output),
		.imm_5bit          (imm_5bit),
		.imm_15bit         (imm_15bit),
		.imm_20bit         (imm_20bit),
		.select_alu_src2   (select_alu_src2),
		.select_imm_extend (select_imm_extend),
		.select_write_reg  (select_write_reg),
		.alu_src2          (alu_src2),
		.write_reg_data    (write_reg_data)
	);

	alu u_alu (
		.op     (alu_op),
		.a      (ra_data),
		.b      (alu_src2),
		.result (alu_output),
		.zero   (zero)
	);

	// byte address from the alu, word index into memory
	data_mem u_dmem (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (mem_we),
		.addr    (alu_output[MEM_ADDR_W+1:2]),
		.wr_data (rt_data),
		.rd_data (mem_read_data)
	);

	assign br_next = is_branch & (zero ^ branch_ne);

	// report lives for one cycle, zero otherwise
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_addr  <= '0;
			wb_data  <= '0;
			br_taken <= 1'b0;
		end else begin
			wb_valid <= reg_we;
			wb_addr  <= reg_we ? rt_addr : '0;
			wb_data  <= reg_we ? write_reg_data : '0;
			br_taken <= br_next;
		end
	end

endmodule

// File: testbench/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;
	import core_pkg::*;

	typedef struct packed {
		logic      valid;
		word_t     instr;
		logic      wb_valid;
		reg_addr_t wb_addr;
		word_t     wb_data;
		logic      br_taken;
		reg_addr_t dbg_addr; // register read back after the instruction
		word_t     dbg_data;
	} row_t;

	logic      clk;
	logic      rst_n;
	logic      instr_valid;
	word_t     instr;
	reg_addr_t dbg_addr;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      br_taken;
	word_t     dbg_data;

	row_t rows[$];
	row_t reset_row;

	exec_core dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dbg_addr    (dbg_addr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.br_taken    (br_taken),
		.dbg_data    (dbg_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// instruction word builders
	function automatic word_t r_word(opcode_t op, reg_addr_t rt, reg_addr_t ra, reg_addr_t rb,
		logic [1:0] sv);
		return {1'b0, op, rt, ra, rb, sv, 8'd0};
	endfunction

	function automatic word_t i_word(opcode_t op, reg_addr_t rt, reg_addr_t ra,
		logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic word_t movi_word(reg_addr_t rt, logic [19:0] imm);
		return {1'b0, OP_MOVI, rt, imm};
	endfunction

	task automatic add_row(input logic v, input word_t w, input logic wv,
		input reg_addr_t wa, input word_t wd, input logic br, input reg_addr_t da,
		input word_t dd);
		rows.push_back({v, w, wv, wa, wd, br, da, dd});
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic value_error(input string what);
		abort_run($sformatf("Mismatch at %0t ns: %s", $time, what));
	endtask

	task automatic check_row(input int idx, input row_t r);
		assert (wb_valid === r.wb_valid) else
			value_error($sformatf("row %0d wb_valid %b expected %b", idx,
				wb_valid, r.wb_valid));
		assert (wb_addr === r.wb_addr) else
			value_error($sformatf("row %0d wb_addr %0d expected %0d", idx,
				wb_addr, r.wb_addr));
		assert (wb_data === r.wb_data) else
			value_error($sformatf("row %0d wb_data %h expected %h", idx,
				wb_data, r.wb_data));
		assert (br_taken === r.br_taken) else
			value_error($sformatf("row %0d br_taken %b expected %b", idx,
				br_taken, r.br_taken));
		assert (dbg_data === r.dbg_data) else
			value_error($sformatf("row %0d r%0d reads %h expected %h", idx, r.dbg_addr,
				dbg_data, r.dbg_data));
	endtask

	initial begin
		int   n;
		logic got;
		row_t last;

		instr_valid <= 1'b0;
		instr       <= '0;
		dbg_addr    <= '0;
		rst_n       <= 1'b0;
		reset_row = '0;

		// immediates, the addi reads the movi result one cycle later
		add_row(1'b1, movi_word(5'd1, 20'hffff0),
			1'b1, 5'd1, 32'hffff_fff0, 1'b0, 5'd1, 32'hffff_fff0);
		add_row(1'b1, i_word(OP_ADDI, 5'd2, 5'd1, 15'h7ffd),
			1'b1, 5'd2, 32'hffff_ffed, 1'b0, 5'd1, 32'hffff_fff0);
		add_row(1'b1, i_word(OP_ORI, 5'd3, 5'd0, 15'h7abc),
			1'b1, 5'd3, 32'h0000_7abc, 1'b0, 5'd2, 32'hffff_ffed);
		add_row(1'b1, i_word(OP_SLLI, 5'd4, 5'd3, 15'h1000),
			1'b1, 5'd4, 32'h0007_abc0, 1'b0, 5'd3, 32'h0000_7abc);
		add_row(1'b1, movi_word(5'd5, 20'd3),
			1'b1, 5'd5, 32'd3, 1'b0, 5'd4, 32'h0007_abc0);
		// register alu ops
		add_row(1'b1, r_word(OP_ADD, 5'd6, 5'd3, 5'd4, 2'd0),
			1'b1, 5'd6, 32'h0008_267c, 1'b0, 5'd5, 32'd3);
		add_row(1'b1, r_word(OP_SUB, 5'd7, 5'd3, 5'd4, 2'd0),
			1'b1, 5'd7, 32'hfff8_cefc, 1'b0, 5'd6, 32'h0008_267c);
		add_row(1'b1, r_word(OP_AND, 5'd8, 5'd1, 5'd3, 2'd0),
			1'b1, 5'd8, 32'h0000_7ab0, 1'b0, 5'd7, 32'hfff8_cefc);
		add_row(1'b1, r_word(OP_OR, 5'd9, 5'd2, 5'd3, 2'd0),
			1'b1, 5'd9, 32'hffff_fffd, 1'b0, 5'd8, 32'h0000_7ab0);
		add_row(1'b1, r_word(OP_XOR, 5'd10, 5'd1, 5'd4, 2'd0),
			1'b1, 5'd10, 32'hfff8_5430, 1'b0, 5'd9, 32'hffff_fffd);
		add_row(1'b1, r_word(OP_SLL, 5'd11, 5'd3, 5'd5, 2'd0),
			1'b1, 5'd11, 32'h0003_d5e0, 1'b0, 5'd10, 32'hfff8_5430);
		add_row(1'b1, r_word(OP_ADD, 5'd0, 5'd3, 5'd5, 2'd0),
			1'b1, 5'd0, 32'h0000_7abf, 1'b0, 5'd0, 32'd0);
		// memory, base 0x40 in r12
		add_row(1'b1, movi_word(5'd12, 20'h40),
			1'b1, 5'd12, 32'h40, 1'b0, 5'd11, 32'h0003_d5e0);
		add_row(1'b1, i_word(OP_SWI, 5'd3, 5'd12, 15'd2),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd12, 32'h40);
		add_row(1'b1, i_word(OP_LWI, 5'd13, 5'd12, 15'd2),
			1'b1, 5'd13, 32'h0000_7abc, 1'b0, 5'd0, 32'd0);
		add_row(1'b1, i_word(OP_SWI, 5'd4, 5'd12, 15'h7fff),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd13, 32'h0000_7abc);
		add_row(1'b1, i_word(OP_LWI, 5'd14, 5'd12, 15'h7fff),
			1'b1, 5'd14, 32'h0007_abc0, 1'b0, 5'd0, 32'd0);
		add_row(1'b1, movi_word(5'd15, 20'd4),
			1'b1, 5'd15, 32'd4, 1'b0, 5'd14, 32'h0007_abc0);
		add_row(1'b1, r_word(OP_SW, 5'd6, 5'd12, 5'd15, 2'd0),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd15, 32'd4);
		add_row(1'b1, r_word(OP_SW, 5'd7, 5'd12, 5'd15, 2'd1),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
		add_row(1'b1, r_word(OP_SW, 5'd8, 5'd12, 5'd15, 2'd2),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
		add_row(1'b1, r_word(OP_SW, 5'd9, 5'd12, 5'd15, 2'd3),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
		add_row(1'b1, r_word(OP_LW, 5'd16, 5'd12, 5'd15, 2'd3),
			1'b1, 5'd16, 32'hffff_fffd, 1'b0, 5'd0, 32'd0);
		add_row(1'b1, r_word(OP_LW, 5'd17, 5'd12, 5'd15, 2'd2),
			1'b1, 5'd17, 32'h0000_7ab0, 1'b0, 5'd16, 32'hffff_fffd);
		add_row(1'b1, r_word(OP_LW, 5'd18, 5'd12, 5'd15, 2'd1),
			1'b1, 5'd18, 32'hfff8_cefc, 1'b0, 5'd17, 32'h0000_7ab0);
		add_row(1'b1, r_word(OP_LW, 5'd19, 5'd12, 5'd15, 2'd0),
			1'b1, 5'd19, 32'h0008_267c, 1'b0, 5'd18, 32'hfff8_cefc);
		// branches compare ra with rt
		add_row(1'b1, i_word(OP_BEQ, 5'd3, 5'd13, 15'd0),
			1'b0, 5'd0, 32'd0, 1'b1, 5'd3, 32'h0000_7abc);
		add_row(1'b1, i_word(OP_BEQ, 5'd3, 5'd4, 15'd0),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd3, 32'h0000_7abc);
		add_row(1'b1, i_word(OP_BNE, 5'd3, 5'd4, 15'd0),
			1'b0, 5'd0, 32'd0, 1'b1, 5'd4, 32'h0007_abc0);
		add_row(1'b1, i_word(OP_BNE, 5'd3, 5'd13, 15'd0),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd13, 32'h0000_7abc);
		// idle cycle holding a taken branch, then an unknown opcode
		add_row(1'b0, i_word(OP_BEQ, 5'd3, 5'd13, 15'd0),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd3, 32'h0000_7abc);
		add_row(1'b1, r_word(6'h3f, 5'd21, 5'd3, 5'd4, 2'd0),
			1'b0, 5'd0, 32'd0, 1'b0, 5'd21, 32'd0);
		add_row(1'b1, i_word(OP_ADDI, 5'd22, 5'd19, 15'd1),
			1'b1, 5'd22, 32'h0008_267d, 1'b0, 5'd22, 32'h0008_267d);

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_row(-1, reset_row); // outputs straight after reset

		// row i goes in on this edge, the report of row i-1 shows up after it
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			instr_valid <= rows[i].valid;
			instr       <= rows[i].instr;
			if (i > 0) begin
				dbg_addr <= rows[i-1].dbg_addr;
			end
			@(negedge clk);
			if (i > 0) begin
				check_row(i - 1, rows[i-1]);
			end
		end

		last = rows[rows.size()-1];
		n = 0;
		got = 1'b0;
		while (!got && n < 20) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			dbg_addr    <= last.dbg_addr;
			@(negedge clk);
			got = wb_valid;
			n++;
		end
		if (!got) begin
			abort_run("timeout: no write-back report for the last instruction");
		end else begin
			check_row(rows.size() - 1, last);
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: build.f
src/core_pkg.sv
src/instr_decode.sv
src/operand_muxes.sv
src/reg_file.sv
src/alu.sv
src/data_mem.sv
src/exec_core.sv
testbench/tb_exec_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the exec_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f build.f \
	--top-module tb_exec_core \
	-Mdir obj_dir \
	-o sim_exec_core

# the simulator exits non-zero on a failure, so the log decides the result
./obj_dir/sim_exec_core 2>&1 | tee sim.log || true

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation ok, see sim.log"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
